//--- rtl/mult_data_pkg.sv
/*
  Multiply unit datapath definitions
  Operand, subword and accumulator vector types, the shift immediate
  and the signedness and subword select pairs, plus the lane counts
  of the dot-product unit.
*/
package mult_data_pkg;

  // Full operand and result word
  typedef logic [31:0] word_t;

  // One subword and its sign-extended form
  typedef logic [15:0] half_t;
  typedef logic [16:0] short_op_t;

  // Short multiply-accumulate result, two guard bits above the word
  typedef logic [33:0] short_acc_t;

  // Shift immediate
  typedef logic [4:0]  shamt_t;

  // Bit 1 belongs to operand B, bit 0 to operand A
  typedef logic [1:0]  signed_sel_t;
  typedef logic [1:0]  subword_sel_t;

  localparam int     HALF_W      = 16;
  // Partial product alignment in the upper-half steps
  localparam shamt_t MULH_SHIFT  = 5'd16;

  localparam int     DOT8_LANES  = 4;
  localparam int     DOT16_LANES = 2;

endpackage

//--- rtl/mult_op_pkg.sv
/*
  Multiply unit operation encodings
  Operator codes presented by the core and the state encoding of the
  multicycle upper-half multiply sequencer.
*/
package mult_op_pkg;

  ////////////////////
  // Operators
  ////////////////////

  typedef enum logic [3:0] {
    // 32-bit multiply-accumulate and multiply-subtract
    MUL_MAC32 = 4'b0000,
    MUL_MSU32 = 4'b0001,
    // 16-bit subword multiply, plain and rounded
    MUL_I     = 4'b0010,
    MUL_IR    = 4'b0011,
    // Dot products onto op_c
    MUL_DOT8  = 4'b0100,
    MUL_DOT16 = 4'b0101,
    // Upper half of the 64-bit product, multicycle
    MUL_H     = 4'b0110
  } mult_op_e;

  ////////////////////
  // MUL_H sequencer
  ////////////////////

  typedef enum logic [2:0] {
    IDLE   = 3'd0,
    STEP0  = 3'd1,
    STEP1  = 3'd2,
    STEP2  = 3'd3,
    FINISH = 3'd4
  } mulh_state_e;

endpackage

//--- rtl/mult_short_datapath.sv
/*
  Short multiplier datapath
  17x17 signed multiply of one selected half of each operand, added to
  op_c and an optional rounding value, then shifted right. Serves the
  subword multiplies and every step of the upper-half multiply.
*/
`timescale 1ns/1ps

module mult_short_datapath (
  input  mult_data_pkg::word_t        op_a_i,
  input  mult_data_pkg::word_t        op_b_i,
  input  mult_data_pkg::word_t        op_c_i,
  input  mult_op_pkg::mult_op_e       operator_i,
  input  mult_data_pkg::shamt_t       imm_i,
  input  logic                        short_subword_i,
  input  mult_data_pkg::signed_sel_t  short_signed_i,

  input  logic                        mulh_active_i,
  input  mult_data_pkg::shamt_t       step_imm_i,
  input  mult_data_pkg::subword_sel_t step_subword_i,
  input  mult_data_pkg::signed_sel_t  step_signed_i,
  input  logic                        step_shift_arith_i,
  input  logic                        carry_i,

  output mult_data_pkg::word_t        short_result_o,
  output logic                        mac_carry_o
);

  import mult_data_pkg::*;
  import mult_op_pkg::*;

  shamt_t       short_imm;
  subword_sel_t short_subword;
  signed_sel_t  short_signed;
  logic         short_shift_arith;

  half_t        half_a;
  half_t        half_b;
  short_op_t    short_op_a;
  short_op_t    short_op_b;
  logic [32:0]  short_op_c;
  short_acc_t   short_mul;
  short_acc_t   short_mac;
  short_acc_t   short_shifted;
  word_t        short_round_tmp;
  word_t        short_round;

  logic         mac_msb1;
  logic         mac_msb0;

  ////////////////////
  // Control select
  ////////////////////

  // Sequencer controls take over while MUL_H runs
  assign short_imm         = mulh_active_i ? step_imm_i         : imm_i;
  assign short_subword     = mulh_active_i ? step_subword_i     : {2{short_subword_i}};
  assign short_signed      = mulh_active_i ? step_signed_i      : short_signed_i;
  assign short_shift_arith = mulh_active_i ? step_shift_arith_i : short_signed_i[0];

  // Half of one shifted left by the immediate, MUL_IR only
  assign short_round_tmp = word_t'(1) << imm_i;
  assign short_round     = (operator_i == MUL_IR) ? {1'b0, short_round_tmp[31:1]} : '0;

  ////////////////////
  // Multiply-add
  ////////////////////

  assign half_a = short_subword[0] ? op_a_i[2*HALF_W-1:HALF_W] : op_a_i[HALF_W-1:0];
  assign half_b = short_subword[1] ? op_b_i[2*HALF_W-1:HALF_W] : op_b_i[HALF_W-1:0];

  assign short_op_a = {short_signed[0] & half_a[HALF_W-1], half_a};
  assign short_op_b = {short_signed[1] & half_b[HALF_W-1], half_b};

  // Saved carry acts as bit 32 of the running partial sum
  assign short_op_c = mulh_active_i ? {carry_i, op_c_i} : {op_c_i[31], op_c_i};

  assign short_mul = $signed(short_op_a) * $signed(short_op_b);
  assign short_mac = $signed(short_op_c) + $signed(short_mul) + $signed(short_round);

  // Upper-half steps keep the two guard bits, subword ops sign-fill from bit 31
  assign mac_msb1 = mulh_active_i ? short_mac[33] : short_mac[31];
  assign mac_msb0 = mulh_active_i ? short_mac[32] : short_mac[31];

  assign short_shifted = $signed({short_shift_arith & mac_msb1,
                                  short_shift_arith & mac_msb0,
                                  short_mac[31:0]}) >>> short_imm;

  assign short_result_o = short_shifted[31:0];
  assign mac_carry_o    = short_mac[32];

  // The sequencer only ever aligns by zero or a full half word
  always_comb begin
    if (mulh_active_i) begin
      a_step_imm: assert final (step_imm_i == '0 || step_imm_i == MULH_SHIFT)
        else $error("MUL_H step shift %0d out of range", step_imm_i);
    end
  end

endmodule

//--- rtl/mult_mulh_ctrl.sv
/*
  Upper-half multiply sequencer
  Builds the upper 32 bits of a 32x32 product from four 16x16 partial
  products on the short datapath, saving the carry between steps, and
  drives the ready and multicycle handshake to the pipeline.
*/
`timescale 1ns/1ps

module mult_mulh_ctrl (
  input  logic                        clk,
  input  logic                        rst_n,

  input  logic                        enable_i,
  input  mult_op_pkg::mult_op_e       operator_i,
  input  mult_data_pkg::signed_sel_t  short_signed_i,
  input  logic                        ex_ready_i,
  input  logic                        mac_carry_i,

  output logic                        mulh_active_o,
  output mult_data_pkg::shamt_t       step_imm_o,
  output mult_data_pkg::subword_sel_t step_subword_o,
  output mult_data_pkg::signed_sel_t  step_signed_o,
  output logic                        step_shift_arith_o,
  output logic                        carry_o,
  output logic                        ready_o,
  output logic                        multicycle_o
);

  import mult_data_pkg::*;
  import mult_op_pkg::*;

  mulh_state_e mulh_state_q;
  mulh_state_e mulh_state_d;

  logic        carry_q;
  logic        carry_save;
  logic        carry_clear;

  ////////////////////
  // Step decode
  ////////////////////

  always_comb begin
    mulh_state_d       = mulh_state_q;
    mulh_active_o      = 1'b1;
    step_imm_o         = '0;
    step_subword_o     = 2'b00;
    step_signed_o      = 2'b00;
    step_shift_arith_o = 1'b0;
    carry_save         = 1'b0;
    carry_clear        = 1'b0;
    ready_o            = 1'b0;
    multicycle_o       = 1'b0;

    case (mulh_state_q)
      IDLE: begin
        mulh_active_o = 1'b0;
        ready_o       = 1'b1;
        if (enable_i && (operator_i == MUL_H)) begin
          ready_o      = 1'b0;
          mulh_state_d = STEP0;
        end
      end

      // AL*BL, unsigned and never overflows, aligned down by 16
      STEP0: begin
        multicycle_o = 1'b1;
        step_imm_o   = MULH_SHIFT;
        mulh_state_d = STEP1;
      end

      // AL*BH, signed with B; 33-bit sum so the carry is kept
      STEP1: begin
        multicycle_o       = 1'b1;
        step_signed_o      = {short_signed_i[1], 1'b0};
        step_subword_o     = 2'b10;
        step_shift_arith_o = 1'b1;
        carry_save         = 1'b1;
        mulh_state_d       = STEP2;
      end

      // AH*BL, signed with A; guard bits shift back so the carry goes
      STEP2: begin
        multicycle_o       = 1'b1;
        step_signed_o      = {1'b0, short_signed_i[0]};
        step_subword_o     = 2'b01;
        step_imm_o         = MULH_SHIFT;
        step_shift_arith_o = 1'b1;
        carry_save         = 1'b1;
        carry_clear        = 1'b1;
        mulh_state_d       = FINISH;
      end

      // AH*BH completes the upper word, held until the pipeline takes it
      FINISH: begin
        step_signed_o  = short_signed_i;
        step_subword_o = 2'b11;
        ready_o        = 1'b1;
        if (ex_ready_i) begin
          mulh_state_d = IDLE;
        end
      end

      default: begin
        mulh_state_d = IDLE;
      end
    endcase
  end

  ////////////////////
  // State and carry
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mulh_state_q <= IDLE;
      carry_q      <= 1'b0;
    end else begin
      mulh_state_q <= mulh_state_d;
      if (carry_save) begin
        carry_q <= ~carry_clear & mac_carry_i;
      end else if (ex_ready_i) begin
        // Next instruction starts with a clean carry
        carry_q <= 1'b0;
      end
    end
  end

  assign carry_o = carry_q;

  a_ready_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(ready_o && multicycle_o));

  a_finish_exit: assert property (@(posedge clk) disable iff (!rst_n)
    (mulh_state_q == FINISH && ex_ready_i) |=> (mulh_state_q == IDLE));

endmodule

//--- rtl/mult_dot_unit.sv
/*
  Dot-product unit
  Four 8-bit lanes or two 16-bit lanes of op_a and op_b multiplied
  pairwise, each lane signed or unsigned per operand, summed onto op_c.
  Results wrap to 32 bits.
*/
`timescale 1ns/1ps

module mult_dot_unit (
  input  mult_data_pkg::word_t       op_a_i,
  input  mult_data_pkg::word_t       op_b_i,
  input  mult_data_pkg::word_t       op_c_i,
  input  mult_data_pkg::signed_sel_t dot_signed_i,

  output mult_data_pkg::word_t       dot8_result_o,
  output mult_data_pkg::word_t       dot16_result_o
);

  import mult_data_pkg::*;

  // Byte lanes carry one extra bit for the sign extension
  logic [DOT8_LANES-1:0][HALF_W/2:0] dot8_op_a;
  logic [DOT8_LANES-1:0][HALF_W/2:0] dot8_op_b;
  word_t                             dot8_mul [DOT8_LANES];
  word_t                             dot8_sum;

  short_op_t                         dot16_op_a [DOT16_LANES];
  short_op_t                         dot16_op_b [DOT16_LANES];
  word_t                             dot16_mul  [DOT16_LANES];
  word_t                             dot16_sum;

  ////////////////////
  // 8-bit lanes
  ////////////////////

  always_comb begin
    dot8_sum = op_c_i;
    for (int i = 0; i < DOT8_LANES; i++) begin
      dot8_op_a[i] = {dot_signed_i[0] & op_a_i[(HALF_W/2)*i + HALF_W/2 - 1],
                      op_a_i[(HALF_W/2)*i +: HALF_W/2]};
      dot8_op_b[i] = {dot_signed_i[1] & op_b_i[(HALF_W/2)*i + HALF_W/2 - 1],
                      op_b_i[(HALF_W/2)*i +: HALF_W/2]};
      // Word-wide product keeps the sign of the lane result
      dot8_mul[i]  = $signed(dot8_op_a[i]) * $signed(dot8_op_b[i]);
      dot8_sum     = dot8_sum + dot8_mul[i];
    end
  end

  ////////////////////
  // 16-bit lanes
  ////////////////////

  always_comb begin
    dot16_sum = op_c_i;
    for (int i = 0; i < DOT16_LANES; i++) begin
      dot16_op_a[i] = {dot_signed_i[0] & op_a_i[HALF_W*i + HALF_W - 1],
                       op_a_i[HALF_W*i +: HALF_W]};
      dot16_op_b[i] = {dot_signed_i[1] & op_b_i[HALF_W*i + HALF_W - 1],
                       op_b_i[HALF_W*i +: HALF_W]};
      // Only the low word of each product matters after wrapping
      dot16_mul[i]  = $signed(dot16_op_a[i]) * $signed(dot16_op_b[i]);
      dot16_sum     = dot16_sum + dot16_mul[i];
    end
  end

  assign dot8_result_o  = dot8_sum;
  assign dot16_result_o = dot16_sum;

endmodule

//--- rtl/mult_top.sv
/*
  Multiply unit top level
  Single-cycle 32-bit MAC and MSU, subword and dot-product multiplies,
  and the four-step upper-half multiply. The result is selected by
  operator and handed back through the enable/ready handshake.
*/
`timescale 1ns/1ps

module mult_top (
  input  logic                       clk,
  input  logic                       rst_n,

  input  logic                       enable_i,
  input  mult_op_pkg::mult_op_e      operator_i,

  input  logic                       short_subword_i,
  input  mult_data_pkg::signed_sel_t short_signed_i,
  input  mult_data_pkg::signed_sel_t dot_signed_i,

  input  mult_data_pkg::word_t       op_a_i,
  input  mult_data_pkg::word_t       op_b_i,
  input  mult_data_pkg::word_t       op_c_i,
  input  mult_data_pkg::shamt_t      imm_i,

  output mult_data_pkg::word_t       result_o,
  output logic                       multicycle_o,
  output logic                       ready_o,
  input  logic                       ex_ready_i
);

  import mult_data_pkg::*;
  import mult_op_pkg::*;

  logic         mulh_active;
  shamt_t       step_imm;
  subword_sel_t step_subword;
  signed_sel_t  step_signed;
  logic         step_shift_arith;
  logic         carry;
  logic         mac_carry;

  word_t        short_result;
  word_t        dot8_result;
  word_t        dot16_result;

  logic         int_is_msu;
  word_t        int_op_a;
  word_t        int_op_b;
  word_t        int_result;

  mult_short_datapath u_short (
    .op_a_i             (op_a_i),
    .op_b_i             (op_b_i),
    .op_c_i             (op_c_i),
    .operator_i         (operator_i),
    .imm_i              (imm_i),
    .short_subword_i    (short_subword_i),
    .short_signed_i     (short_signed_i),
    .mulh_active_i      (mulh_active),
    .step_imm_i         (step_imm),
    .step_subword_i     (step_subword),
    .step_signed_i      (step_signed),
    .step_shift_arith_i (step_shift_arith),
    .carry_i            (carry),
    .short_result_o     (short_result),
    .mac_carry_o        (mac_carry)
  );

  mult_mulh_ctrl u_mulh_ctrl (
    .clk                (clk),
    .rst_n              (rst_n),
    .enable_i           (enable_i),
    .operator_i         (operator_i),
    .short_signed_i     (short_signed_i),
    .ex_ready_i         (ex_ready_i),
    .mac_carry_i        (mac_carry),
    .mulh_active_o      (mulh_active),
    .step_imm_o         (step_imm),
    .step_subword_o     (step_subword),
    .step_signed_o      (step_signed),
    .step_shift_arith_o (step_shift_arith),
    .carry_o            (carry),
    .ready_o            (ready_o),
    .multicycle_o       (multicycle_o)
  );

  mult_dot_unit u_dot (
    .op_a_i         (op_a_i),
    .op_b_i         (op_b_i),
    .op_c_i         (op_c_i),
    .dot_signed_i   (dot_signed_i),
    .dot8_result_o  (dot8_result),
    .dot16_result_o (dot16_result)
  );

  ////////////////////
  // 32-bit MAC / MSU
  ////////////////////

  // c - a*b as c + (~a)*b + b, sharing one multiplier with the MAC
  assign int_is_msu = (operator_i == MUL_MSU32);
  assign int_op_a   = op_a_i ^ {32{int_is_msu}};
  assign int_op_b   = op_b_i & {32{int_is_msu}};
  assign int_result = op_c_i + int_op_b + int_op_a * op_b_i;

  always_comb begin
    unique case (operator_i)
      MUL_MAC32, MUL_MSU32: result_o = int_result;
      MUL_I, MUL_IR, MUL_H: result_o = short_result;
      MUL_DOT8:             result_o = dot8_result;
      MUL_DOT16:            result_o = dot16_result;
      default:              result_o = '0;
    endcase
  end

  // Upper word of a 64-bit product of already extended operands
  function automatic word_t mulh_upper(input logic [63:0] a, input logic [63:0] b);
    logic [63:0] prod;
    prod = a * b;
    return prod[63:32];
  endfunction

  a_mulh_ss: assert property (@(posedge clk) disable iff (!rst_n)
    (u_mulh_ctrl.mulh_state_q == FINISH && operator_i == MUL_H && short_signed_i == 2'b11)
    |-> (result_o == mulh_upper({{32{op_a_i[31]}}, op_a_i}, {{32{op_b_i[31]}}, op_b_i})));

  a_mulh_su: assert property (@(posedge clk) disable iff (!rst_n)
    (u_mulh_ctrl.mulh_state_q == FINISH && operator_i == MUL_H && short_signed_i == 2'b01)
    |-> (result_o == mulh_upper({{32{op_a_i[31]}}, op_a_i}, {32'b0, op_b_i})));

  a_mulh_uu: assert property (@(posedge clk) disable iff (!rst_n)
    (u_mulh_ctrl.mulh_state_q == FINISH && operator_i == MUL_H && short_signed_i == 2'b00)
    |-> (result_o == mulh_upper({32'b0, op_a_i}, {32'b0, op_b_i})));

endmodule

//--- testbench/tb_mult.sv
/*
  Multiply unit testbench
  Drives MAC/MSU, subword, upper-half and dot-product operations
  through the enable/ready handshake. Concurrent assertions compare
  every result with a behavioral model of the instruction rules.
*/
`timescale 1ns/1ps

module tb_mult;

  import mult_data_pkg::*;
  import mult_op_pkg::*;

  logic        clk;
  logic        rst_n;
  logic        enable;
  mult_op_e    operator;
  logic        short_subword;
  signed_sel_t short_signed;
  signed_sel_t dot_signed;
  word_t       op_a;
  word_t       op_b;
  word_t       op_c;
  shamt_t      imm;
  logic        ex_ready;
  word_t       result;
  logic        multicycle;
  logic        ready;

  int          seed;
  signed_sel_t mulh_modes [3] = '{2'b11, 2'b01, 2'b00};

  mult_top u_mult_top (
    .clk             (clk),
    .rst_n           (rst_n),
    .enable_i        (enable),
    .operator_i      (operator),
    .short_subword_i (short_subword),
    .short_signed_i  (short_signed),
    .dot_signed_i    (dot_signed),
    .op_a_i          (op_a),
    .op_b_i          (op_b),
    .op_c_i          (op_c),
    .imm_i           (imm),
    .result_o        (result),
    .multicycle_o    (multicycle),
    .ready_o         (ready),
    .ex_ready_i      (ex_ready)
  );

  always #2 clk = ~clk;

  ////////////////////
  // Reference model
  ////////////////////

  // Field of the given width, sign or zero extended
  function automatic longint lane_value(input word_t v, input int width, input bit is_signed);
    longint x;
    x = longint'(v) & ((longint'(1) << width) - 1);
    if (is_signed && x[width-1]) begin
      x = x - (longint'(1) << width);
    end
    return x;
  endfunction

  function automatic word_t mac_model(input word_t a, b, c, input bit subtract);
    word_t prod;
    prod = a * b;
    return subtract ? c - prod : c + prod;
  endfunction

  function automatic word_t subword_model(input word_t a, b, c, input logic hi,
                                          input signed_sel_t sgn, input shamt_t sh,
                                          input bit round);
    longint ea;
    longint eb;
    word_t  sum;
    word_t  res;
    ea  = lane_value(hi ? (a >> HALF_W) : a, HALF_W, sgn[0]);
    eb  = lane_value(hi ? (b >> HALF_W) : b, HALF_W, sgn[1]);
    sum = c + word_t'(ea * eb);
    if (round && sh != '0) begin
      sum = sum + (word_t'(1) << (sh - 1));
    end
    if (sgn[0]) begin
      res = word_t'($signed(sum) >>> sh);
    end else begin
      res = sum >> sh;
    end
    return res;
  endfunction

  function automatic word_t mulh_model(input word_t a, b, input signed_sel_t sgn);
    longint prod;
    prod = lane_value(a, 32, sgn[0]) * lane_value(b, 32, sgn[1]);
    return prod[63:32];
  endfunction

  function automatic word_t dot_model(input word_t a, b, c, input signed_sel_t sgn,
                                      input int width);
    longint acc;
    acc = longint'(c);
    for (int i = 0; i < 32 / width; i++) begin
      acc = acc + lane_value(a >> (i * width), width, sgn[0]) *
                  lane_value(b >> (i * width), width, sgn[1]);
    end
    return word_t'(acc);
  endfunction

  ////////////////////
  // Failure reporting
  ////////////////////

  task automatic report_mismatch(input string msg);
    $display("FAILED at time %0t: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Gave up after 20 cycles waiting for ready on %s", what);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  ////////////////////
  // Checks
  ////////////////////

  a_reset_state: assert property (@(posedge clk) !rst_n |-> (ready && !multicycle))
    else report_mismatch("ready/multicycle wrong in reset");

  a_idle_state: assert property (@(posedge clk) disable iff (!rst_n)
    !enable |-> (ready && !multicycle))
    else report_mismatch("ready/multicycle wrong while idle");

  a_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    (enable && operator != MUL_H) |-> (ready && !multicycle))
    else report_mismatch("single-cycle operation not ready");

  a_mac: assert property (@(posedge clk) disable iff (!rst_n)
    (enable && (operator == MUL_MAC32 || operator == MUL_MSU32))
    |-> (result == mac_model(op_a, op_b, op_c, operator == MUL_MSU32)))
    else report_mismatch($sformatf("MAC/MSU result %h", $sampled(result)));

  a_subword: assert property (@(posedge clk) disable iff (!rst_n)
    (enable && (operator == MUL_I || operator == MUL_IR))
    |-> (result == subword_model(op_a, op_b, op_c, short_subword, short_signed, imm,
                                 operator == MUL_IR)))
    else report_mismatch($sformatf("subword result %h", $sampled(result)));

  a_dot: assert property (@(posedge clk) disable iff (!rst_n)
    (enable && (operator == MUL_DOT8 || operator == MUL_DOT16))
    |-> (result == dot_model(op_a, op_b, op_c, dot_signed,
                             (operator == MUL_DOT8) ? 8 : 16)))
    else report_mismatch($sformatf("dot product result %h", $sampled(result)));

  // Accept cycle, three busy cycles, then the upper word
  a_mulh_timing: assert property (@(posedge clk) disable iff (!rst_n)
    (enable && operator == MUL_H && !ready && !multicycle)
    |=> (!ready && multicycle) [*3]
        ##1 (ready && !multicycle && result == mulh_model(op_a, op_b, short_signed)))
    else report_mismatch($sformatf("MUL_H sequence or result %h", $sampled(result)));

  a_mulh_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (enable && operator == MUL_H && ready && !ex_ready) |=> (ready && $stable(result)))
    else report_mismatch("MUL_H result not held under back-pressure");

  ////////////////////
  // Stimulus
  ////////////////////

  // The core forwards each MUL_H partial result back on op_c
  task automatic wait_ready(input bit complete, input string what);
    int   cycles;
    bit   done;
    bit   fwd;
    word_t fwd_value;
    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < 20) begin
      @(negedge clk);
      done = ready && (ex_ready || !complete);
      if (!done) begin
        cycles++;
        fwd       = multicycle;
        fwd_value = result;
        @(posedge clk);
        #1;
        if (fwd) begin
          op_c = fwd_value;
        end
      end
    end
    if (!done) begin
      abort_on_timeout(what);
    end else if (complete) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic run_op(input mult_op_e o, input word_t a, b, c, input logic sub,
                        input signed_sel_t ss, ds, input shamt_t sh, input bit take);
    enable        = 1'b1;
    operator      = o;
    op_a          = a;
    op_b          = b;
    op_c          = c;
    short_subword = sub;
    short_signed  = ss;
    dot_signed    = ds;
    imm           = sh;
    ex_ready      = take;
    wait_ready(take, o.name());
  endtask

  initial begin
    seed          = 2;
    clk           = 1'b0;
    rst_n         = 1'b0;
    enable        = 1'b0;
    operator      = MUL_MAC32;
    short_subword = 1'b0;
    short_signed  = 2'b00;
    dot_signed    = 2'b00;
    op_a          = '0;
    op_b          = '0;
    op_c          = '0;
    imm           = '0;
    ex_ready      = 1'b1;

    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (2) @(posedge clk);
    #1;

    for (int i = 0; i < 8; i++) begin
      run_op(MUL_MAC32, $random(seed), $random(seed), $random(seed), 0, 0, 0, 0, 1'b1);
      run_op(MUL_MSU32, $random(seed), $random(seed), $random(seed), 0, 0, 0, 0, 1'b1);
    end

    // Rounding with a zero shift adds nothing
    run_op(MUL_IR, 32'h0003_8001, 32'hffff_7fff, 32'h1234_5678, 1'b0, 2'b11, 0, 0, 1'b1);
    for (int i = 0; i < 24; i++) begin
      run_op((i % 2) ? MUL_IR : MUL_I, $random(seed), $random(seed), $random(seed),
             $random(seed), $random(seed), 0, $random(seed), 1'b1);
    end

    enable = 1'b0;
    @(posedge clk);
    #1;

    foreach (mulh_modes[m]) begin
      run_op(MUL_H, 32'h8000_0000, 32'h8000_0000, '0, 0, mulh_modes[m], 0, 0, 1'b1);
      run_op(MUL_H, 32'hffff_ffff, 32'hffff_ffff, '0, 0, mulh_modes[m], 0, 0, 1'b1);
      run_op(MUL_H, 32'h7fff_ffff, 32'h8000_0001, '0, 0, mulh_modes[m], 0, 0, 1'b1);
      for (int i = 0; i < 4; i++) begin
        run_op(MUL_H, $random(seed), $random(seed), '0, 0, mulh_modes[m], 0, 0, 1'b1);
      end
    end

    // Pipeline stalls while the upper word waits in FINISH
    run_op(MUL_H, $random(seed), $random(seed), '0, 0, 2'b01, 0, 0, 1'b0);
    repeat (5) @(posedge clk);
    #1;
    ex_ready = 1'b1;
    wait_ready(1'b1, "MUL_H release");
    run_op(MUL_MAC32, $random(seed), $random(seed), $random(seed), 0, 0, 0, 0, 1'b1);

    for (int s = 0; s < 4; s++) begin
      for (int i = 0; i < 3; i++) begin
        run_op(MUL_DOT8, $random(seed), $random(seed), $random(seed), 0, 0,
               signed_sel_t'(s), 0, 1'b1);
        run_op(MUL_DOT16, $random(seed), $random(seed), $random(seed), 0, 0,
               signed_sel_t'(s), 0, 1'b1);
      end
    end

    enable = 1'b0;
    repeat (3) @(posedge clk);
    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- files.f
rtl/mult_data_pkg.sv
rtl/mult_op_pkg.sv
rtl/mult_short_datapath.sv
rtl/mult_mulh_ctrl.sv
rtl/mult_dot_unit.sv
rtl/mult_top.sv
testbench/tb_mult.sv
